// File: ocl_hello_params.svh
`ifndef OCL_HELLO_PARAMS_SVH
`define OCL_HELLO_PARAMS_SVH

// ----------------------------------------------------------------------
// AXI4-Lite bus widths
// ----------------------------------------------------------------------
`define OCL_ADDR_W 32
`define OCL_DATA_W 32
`define OCL_BYTE_LANES (`OCL_DATA_W / 8)

// Response code width and the only code this slave returns
`define AXI_RESP_W 2
`define AXI_RESP_OKAY 2'b00

// Virtual LEDs and DIP switches
`define VLED_W 16

// ----------------------------------------------------------------------
// Register map
// ----------------------------------------------------------------------
`define HELLO_WORLD_REG_ADDR 32'h0000_0500
`define VLED_REG_ADDR 32'h0000_0504

// Read value for any unmapped address
`define UNIMPLEMENTED_REG_VALUE 32'hdeaf_beef

`endif

// File: ocl_hello_pkg.sv
`default_nettype none

`include "ocl_hello_params.svh"

package ocl_hello_pkg;

   // ----------------------------------------------------------------------
   // Register word types
   // ----------------------------------------------------------------------

   // One byte lane of a register word
   typedef logic [7:0] reg_byte_t;

   // Hello-world word, seen two ways
   // Whole word for bus writes and model compares
   // Byte lanes for the swap and the LED shadow
   typedef union packed {
      logic [`OCL_DATA_W-1:0]                word;
      reg_byte_t [`OCL_BYTE_LANES-1:0]       lanes;
   } hello_word_u;

endpackage

`default_nettype wire

// File: ocl_axil_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module ocl_axil_ctrl (
   input  wire                     clk_main_a0,
   input  wire                     rst_main_n_sync,
   // Write address channel
   input  wire                     i_awvalid,
   input  wire [`OCL_ADDR_W-1:0]   i_awaddr,
   output logic                    o_awready,
   // Write data channel
   input  wire                     i_wvalid,
   input  wire [`OCL_DATA_W-1:0]   i_wdata,
   output logic                    o_wready,
   // Write response channel
   input  wire                     i_bready,
   output logic                    o_bvalid,
   output logic [`AXI_RESP_W-1:0]  o_bresp,
   // Read address channel
   input  wire                     i_arvalid,
   input  wire [`OCL_ADDR_W-1:0]   i_araddr,
   output logic                    o_arready,
   // Read data channel
   input  wire                     i_rready,
   output logic                    o_rvalid,
   output logic [`OCL_DATA_W-1:0]  o_rdata,
   output logic [`AXI_RESP_W-1:0]  o_rresp,
   // Internal register access
   output logic                    o_wr_en,
   output logic [`OCL_ADDR_W-1:0]  o_wr_addr,
   output logic [`OCL_DATA_W-1:0]  o_wr_data,
   output logic                    o_rd_req,
   output logic [`OCL_ADDR_W-1:0]  o_rd_addr,
   input  wire [`OCL_DATA_W-1:0]   i_rd_data
);

   logic                   wr_active_q;
   logic [`OCL_ADDR_W-1:0] wr_addr_q;
   logic                   bvalid_q;
   logic                   ar_pend_q;
   logic [`OCL_ADDR_W-1:0] rd_addr_q;
   logic                   rd_req_q;
   logic                   rvalid_q;
   logic                   aw_hs;
   logic                   w_hs;
   logic                   ar_hs;
   logic                   r_hs;

   // ----------------------------------------------------------------------
   // Write path
   // ----------------------------------------------------------------------

   // No new address while a write or its response is open
   assign o_awready = ~wr_active_q & ~bvalid_q;
   assign aw_hs     = i_awvalid & o_awready;

   // Data beat only after the address is in
   assign o_wready  = wr_active_q & i_wvalid;
   assign w_hs      = o_wready;

   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         wr_active_q <= 1'b0;
         bvalid_q    <= 1'b0;
      end
      else
      begin
         // Open on address, close on the data beat
         if (aw_hs)
            wr_active_q <= 1'b1;
         else if (w_hs)
            wr_active_q <= 1'b0;
         // Response one edge after the data beat
         if (w_hs)
            bvalid_q <= 1'b1;
         else if (bvalid_q && i_bready)
            bvalid_q <= 1'b0;
      end
   end

   // Captured write address
   always_ff @(posedge clk_main_a0)
   begin
      if (aw_hs)
         wr_addr_q <= i_awaddr;
   end

   // Each data beat is one write strobe
   assign o_wr_en   = w_hs;
   assign o_wr_addr = wr_addr_q;
   assign o_wr_data = i_wdata;
   assign o_bvalid  = bvalid_q;
   assign o_bresp   = `AXI_RESP_OKAY;

   // ----------------------------------------------------------------------
   // Read path
   // ----------------------------------------------------------------------

   // Blocked from address handshake until the data handshake
   assign o_arready = ~ar_pend_q & ~rd_req_q & ~rvalid_q;
   assign ar_hs     = i_arvalid & o_arready;
   assign r_hs      = rvalid_q & i_rready;

   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         ar_pend_q <= 1'b0;
         rd_req_q  <= 1'b0;
         rvalid_q  <= 1'b0;
      end
      else
      begin
         // Address stage, then one-cycle read strobe
         ar_pend_q <= ar_hs;
         rd_req_q  <= ar_pend_q;
         // rvalid together with the mux capture
         if (rd_req_q)
            rvalid_q <= 1'b1;
         else if (r_hs)
            rvalid_q <= 1'b0;
      end
   end

   // Captured read address
   always_ff @(posedge clk_main_a0)
   begin
      if (ar_hs)
         rd_addr_q <= i_araddr;
   end

   assign o_rd_req  = rd_req_q;
   assign o_rd_addr = rd_addr_q;

   // Read data only shown while valid, zero otherwise
   assign o_rvalid  = rvalid_q;
   assign o_rdata   = rvalid_q ? i_rd_data : '0;
   assign o_rresp   = `AXI_RESP_OKAY;

endmodule

`default_nettype wire

// File: hello_world_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module hello_world_reg
   import ocl_hello_pkg::*;
(
   input  wire                     clk_main_a0,
   input  wire                     rst_main_n_sync,
   input  wire                     i_wr_en,
   input  wire [`OCL_ADDR_W-1:0]   i_wr_addr,
   input  wire [`OCL_DATA_W-1:0]   i_wr_data,
   output hello_word_u             o_hello,
   output hello_word_u             o_hello_swapped
);

   hello_word_u hello_q;

   // ----------------------------------------------------------------------
   // Storage
   // ----------------------------------------------------------------------

   // Full-word write, only at our own address
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
         hello_q.word <= '0;
      else if (i_wr_en && (i_wr_addr == `HELLO_WORLD_REG_ADDR))
         hello_q.word <= i_wr_data;
   end

   // ----------------------------------------------------------------------
   // Byte-swapped read view
   // ----------------------------------------------------------------------
   always_comb
   begin
      // Lane order reversed, lane 0 gets lane 3
      for (int i = 0; i < `OCL_BYTE_LANES; i++)
         o_hello_swapped.lanes[i] = hello_q.lanes[`OCL_BYTE_LANES-1-i];
   end

   assign o_hello = hello_q;

endmodule

`default_nettype wire

// File: vled_status.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module vled_status
   import ocl_hello_pkg::*;
(
   input  wire                     clk_main_a0,
   input  wire                     rst_main_n_sync,
   input  wire hello_word_u        i_hello,
   input  wire [`VLED_W-1:0]       i_status_vdip,
   output logic [`VLED_W-1:0]      o_vled,
   output logic [`VLED_W-1:0]      o_status_vled
);

   logic [`VLED_W-1:0] vled_q;
   logic [`VLED_W-1:0] vdip_q;
   logic [`VLED_W-1:0] vdip_q2;
   logic [`VLED_W-1:0] status_vled_q;

   // ----------------------------------------------------------------------
   // LED shadow of the hello-world low half
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
         vled_q <= '0;
      else
         vled_q <= i_hello.lanes[1:0];
   end

   // ----------------------------------------------------------------------
   // DIP switch sync and masked LED output
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         vdip_q        <= '0;
         vdip_q2       <= '0;
         status_vled_q <= '0;
      end
      else
      begin
         // Two flops, switches come from another domain
         vdip_q        <= i_status_vdip;
         vdip_q2       <= vdip_q;
         // LED lit only where its switch is on
         status_vled_q <= vled_q & vdip_q2;
      end
   end

   assign o_vled        = vled_q;
   assign o_status_vled = status_vled_q;

endmodule

`default_nettype wire

// File: ocl_rdata_mux.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module ocl_rdata_mux
   import ocl_hello_pkg::*;
(
   input  wire                     clk_main_a0,
   input  wire                     rst_main_n_sync,
   input  wire                     i_rd_req,
   input  wire [`OCL_ADDR_W-1:0]   i_rd_addr,
   input  wire hello_word_u        i_hello_swapped,
   input  wire [`VLED_W-1:0]       i_vled,
   output logic [`OCL_DATA_W-1:0]  o_rd_data
);

   logic [`OCL_DATA_W-1:0] rd_data_q;

   // ----------------------------------------------------------------------
   // Address decode, captured on the read strobe
   // ----------------------------------------------------------------------
   always_ff @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
         rd_data_q <= '0;
      else if (i_rd_req)
      begin
         case (i_rd_addr)
            // Hello word reads back byte-swapped
            `HELLO_WORLD_REG_ADDR:
               rd_data_q <= i_hello_swapped.word;
            // LED shadow in the low half
            `VLED_REG_ADDR:
               rd_data_q <= {{(`OCL_DATA_W-`VLED_W){1'b0}}, i_vled};
            // Anything else is unmapped
            default:
               rd_data_q <= `UNIMPLEMENTED_REG_VALUE;
         endcase
      end
   end

   // Held until the next read strobe
   assign o_rd_data = rd_data_q;

endmodule

`default_nettype wire

// File: cl_hello_world.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module cl_hello_world (
   input  wire                     clk_main_a0,
   input  wire                     rst_main_n_sync,
   // AXI4-Lite slave from the host
   input  wire                     i_awvalid,
   input  wire [`OCL_ADDR_W-1:0]   i_awaddr,
   output logic                    o_awready,
   input  wire                     i_wvalid,
   input  wire [`OCL_DATA_W-1:0]   i_wdata,
   output logic                    o_wready,
   output logic                    o_bvalid,
   output logic [`AXI_RESP_W-1:0]  o_bresp,
   input  wire                     i_bready,
   input  wire                     i_arvalid,
   input  wire [`OCL_ADDR_W-1:0]   i_araddr,
   output logic                    o_arready,
   output logic                    o_rvalid,
   output logic [`OCL_DATA_W-1:0]  o_rdata,
   output logic [`AXI_RESP_W-1:0]  o_rresp,
   input  wire                     i_rready,
   // Virtual DIP switches and LEDs
   input  wire [`VLED_W-1:0]       i_status_vdip,
   output logic [`VLED_W-1:0]      o_status_vled
);

   // Register access strobes
   logic                   wr_en;
   logic [`OCL_ADDR_W-1:0] wr_addr;
   logic [`OCL_DATA_W-1:0] wr_data;
   logic                   rd_req;
   logic [`OCL_ADDR_W-1:0] rd_addr;
   logic [`OCL_DATA_W-1:0] rd_data;
   // Register values
   logic [`OCL_DATA_W-1:0] hello;
   logic [`OCL_DATA_W-1:0] hello_swapped;
   logic [`VLED_W-1:0]     vled;

   // ----------------------------------------------------------------------
   // AXI4-Lite channel control
   // ----------------------------------------------------------------------
   ocl_axil_ctrl u_axil_ctrl (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_awvalid       (i_awvalid),
      .i_awaddr        (i_awaddr),
      .o_awready       (o_awready),
      .i_wvalid        (i_wvalid),
      .i_wdata         (i_wdata),
      .o_wready        (o_wready),
      .i_bready        (i_bready),
      .o_bvalid        (o_bvalid),
      .o_bresp         (o_bresp),
      .i_arvalid       (i_arvalid),
      .i_araddr        (i_araddr),
      .o_arready       (o_arready),
      .i_rready        (i_rready),
      .o_rvalid        (o_rvalid),
      .o_rdata         (o_rdata),
      .o_rresp         (o_rresp),
      .o_wr_en         (wr_en),
      .o_wr_addr       (wr_addr),
      .o_wr_data       (wr_data),
      .o_rd_req        (rd_req),
      .o_rd_addr       (rd_addr),
      .i_rd_data       (rd_data)
   );

   // ----------------------------------------------------------------------
   // Registers and read-back
   // ----------------------------------------------------------------------
   hello_world_reg u_hello_world_reg (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_wr_en         (wr_en),
      .i_wr_addr       (wr_addr),
      .i_wr_data       (wr_data),
      .o_hello         (hello),
      .o_hello_swapped (hello_swapped)
   );

   // LED shadow, masked by the DIP switches
   vled_status u_vled_status (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_hello         (hello),
      .i_status_vdip   (i_status_vdip),
      .o_vled          (vled),
      .o_status_vled   (o_status_vled)
   );

   ocl_rdata_mux u_rdata_mux (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_rd_req        (rd_req),
      .i_rd_addr       (rd_addr),
      .i_hello_swapped (hello_swapped),
      .i_vled          (vled),
      .o_rd_data       (rd_data)
   );

endmodule

`default_nettype wire

// File: tb_ocl_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module tb_ocl_checker
   import ocl_hello_pkg::*;
(
   input  wire                     clk_main_a0,
   input  wire                     rst_main_n_sync,
   input  wire                     i_awvalid,
   input  wire [`OCL_ADDR_W-1:0]   i_awaddr,
   input  wire                     i_awready,
   input  wire                     i_wvalid,
   input  wire [`OCL_DATA_W-1:0]   i_wdata,
   input  wire                     i_wready,
   input  wire                     i_bvalid,
   input  wire [`AXI_RESP_W-1:0]   i_bresp,
   input  wire                     i_bready,
   input  wire                     i_arvalid,
   input  wire [`OCL_ADDR_W-1:0]   i_araddr,
   input  wire                     i_arready,
   input  wire                     i_rvalid,
   input  wire [`OCL_DATA_W-1:0]   i_rdata,
   input  wire [`AXI_RESP_W-1:0]   i_rresp,
   input  wire                     i_rready,
   input  wire [`VLED_W-1:0]       i_status_vdip,
   input  wire [`VLED_W-1:0]       i_status_vled,
   output int                      o_error_count,
   output int                      o_writes_done,
   output int                      o_reads_done
);

   // Newest-first hello word model over the last three edges
   hello_word_u            hist0;
   hello_word_u            hist1;
   hello_word_u            hist2;
   hello_word_u            swapped;
   // DIP switch samples of the last three edges
   logic [`VLED_W-1:0]     dip_d1;
   logic [`VLED_W-1:0]     dip_d2;
   logic [`VLED_W-1:0]     dip_d3;
   logic [`OCL_ADDR_W-1:0] wr_addr_m;
   logic [`OCL_ADDR_W-1:0] rd_addr_m;
   logic [`OCL_DATA_W-1:0] rd_exp;
   logic                   aw_open;
   logic                   b_due;
   logic                   in_reset;
   // 0 idle, 1 strobe edge, 2 capture edge, 3 rvalid expected
   int                     rd_stage;

   task automatic flag_error(input string msg);
      o_error_count++;
      $display("[ERROR] %0t: %s", $time, msg);
   endtask

   initial
   begin
      o_error_count = 0;
      o_writes_done = 0;
      o_reads_done  = 0;
      in_reset      = 1'b0;
   end

   // ----------------------------------------------------------------------
   // All inputs sampled as they stood just before the edge
   // ----------------------------------------------------------------------
   always @(posedge clk_main_a0)
   begin
      if (!rst_main_n_sync)
      begin
         hist0    = '0;
         hist1    = '0;
         hist2    = '0;
         dip_d1   = '0;
         dip_d2   = '0;
         dip_d3   = '0;
         aw_open  = 1'b0;
         b_due    = 1'b0;
         rd_stage = 0;
         in_reset = 1'b1;
      end
      else
      begin
         // First edge out of reset shows the reset state
         if (in_reset)
         begin
            if (i_awready !== 1'b1 || i_arready !== 1'b1 || i_bvalid !== 1'b0 ||
                i_rvalid !== 1'b0 || i_status_vled !== '0)
               flag_error("outputs not in their reset state after reset");
            in_reset = 1'b0;
         end

         // Address channels stay closed while a transfer is open
         if (i_awready && (aw_open || b_due))
            flag_error("awready high while a write is open");
         if (i_arready && rd_stage != 0)
            flag_error("arready high while a read is open");

         // LED output vs shadow and switch history
         if (i_status_vled !== (hist2.lanes[1:0] & dip_d3))
            flag_error($sformatf("LED output 0x%04h, expected 0x%04h",
                                 i_status_vled, hist2.lanes[1:0] & dip_d3));
         hist2  = hist1;
         hist1  = hist0;
         dip_d3 = dip_d2;
         dip_d2 = dip_d1;
         dip_d1 = i_status_vdip;

         // Write response belongs to an earlier data beat
         if (i_bvalid)
         begin
            if (!b_due)
               flag_error("bvalid without an open write");
            if (i_bresp !== `AXI_RESP_OKAY)
               flag_error($sformatf("bresp 0x%0h, expected OKAY", i_bresp));
            if (i_bready)
            begin
               b_due = 1'b0;
               o_writes_done++;
            end
         end
         else if (b_due)
            flag_error("bvalid missing after the write data beat");

         // Data beat updates the model on its own edge
         if (i_wvalid && i_wready)
         begin
            if (!aw_open)
               flag_error("write data accepted before its address");
            if (wr_addr_m == `HELLO_WORLD_REG_ADDR)
               hist0.word = i_wdata;
            aw_open = 1'b0;
            b_due   = 1'b1;
         end

         if (i_awvalid && i_awready)
         begin
            aw_open   = 1'b1;
            wr_addr_m = i_awaddr;
         end

         // Read pipeline
         case (rd_stage)
            1:
            begin
               // Lane 0 goes to the top byte
               swapped.lanes = {hist0.lanes[0], hist0.lanes[1],
                                hist0.lanes[2], hist0.lanes[3]};
               if (rd_addr_m == `HELLO_WORLD_REG_ADDR)
                  rd_exp = swapped.word;
               else if (rd_addr_m == `VLED_REG_ADDR)
                  rd_exp = {{(`OCL_DATA_W-`VLED_W){1'b0}}, hist1.lanes[1:0]};
               else
                  rd_exp = `UNIMPLEMENTED_REG_VALUE;
               rd_stage = 2;
            end
            2:
            begin
               if (i_rvalid)
                  flag_error("rvalid one edge early");
               rd_stage = 3;
            end
            3:
            begin
               if (!i_rvalid)
               begin
                  flag_error("rvalid missing two edges after the read address");
                  rd_stage = 0;
               end
               else
               begin
                  // Checked on every cycle while rready is low
                  if (i_rdata !== rd_exp)
                     flag_error($sformatf("read 0x%08h at 0x%08h, expected 0x%08h",
                                          i_rdata, rd_addr_m, rd_exp));
                  if (i_rresp !== `AXI_RESP_OKAY)
                     flag_error($sformatf("rresp 0x%0h, expected OKAY", i_rresp));
                  if (i_rready)
                  begin
                     rd_stage = 0;
                     o_reads_done++;
                  end
               end
            end
            default:
            begin
               if (i_rvalid)
                  flag_error("rvalid without an open read");
            end
         endcase

         if (i_arvalid && i_arready)
         begin
            rd_addr_m = i_araddr;
            rd_stage  = 1;
         end
      end
   end

endmodule

`default_nettype wire

// File: tb_cl_hello_world.sv
`timescale 1ns/1ps
`default_nettype none

`include "ocl_hello_params.svh"

module tb_cl_hello_world;

   localparam int NUM_ACCESSES   = 200;
   localparam int TIMEOUT_CYCLES = 50;
   // Channel selectors for the handshake wait
   localparam int CH_AW = 0;
   localparam int CH_W  = 1;
   localparam int CH_B  = 2;
   localparam int CH_AR = 3;
   localparam int CH_R  = 4;

   logic                   clk_main_a0;
   logic                   rst_main_n_sync;
   logic                   awvalid;
   logic [`OCL_ADDR_W-1:0] awaddr;
   logic                   wvalid;
   logic [`OCL_DATA_W-1:0] wdata;
   logic                   bready;
   logic                   arvalid;
   logic [`OCL_ADDR_W-1:0] araddr;
   logic                   rready;
   logic [`VLED_W-1:0]     status_vdip;
   logic                   o_awready;
   logic                   o_wready;
   logic                   o_bvalid;
   logic [`AXI_RESP_W-1:0] o_bresp;
   logic                   o_arready;
   logic                   o_rvalid;
   logic [`OCL_DATA_W-1:0] o_rdata;
   logic [`AXI_RESP_W-1:0] o_rresp;
   logic [`VLED_W-1:0]     o_status_vled;
   int                     error_count;
   int                     writes_done;
   int                     reads_done;
   int                     timeout_count;
   int                     count_errors;
   int                     writes_issued;
   int                     reads_issued;
   int                     seed;
   int                     sel;

   cl_hello_world u_dut (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_awvalid       (awvalid),
      .i_awaddr        (awaddr),
      .o_awready       (o_awready),
      .i_wvalid        (wvalid),
      .i_wdata         (wdata),
      .o_wready        (o_wready),
      .o_bvalid        (o_bvalid),
      .o_bresp         (o_bresp),
      .i_bready        (bready),
      .i_arvalid       (arvalid),
      .i_araddr        (araddr),
      .o_arready       (o_arready),
      .o_rvalid        (o_rvalid),
      .o_rdata         (o_rdata),
      .o_rresp         (o_rresp),
      .i_rready        (rready),
      .i_status_vdip   (status_vdip),
      .o_status_vled   (o_status_vled)
   );

   tb_ocl_checker u_checker (
      .clk_main_a0     (clk_main_a0),
      .rst_main_n_sync (rst_main_n_sync),
      .i_awvalid       (awvalid),
      .i_awaddr        (awaddr),
      .i_awready       (o_awready),
      .i_wvalid        (wvalid),
      .i_wdata         (wdata),
      .i_wready        (o_wready),
      .i_bvalid        (o_bvalid),
      .i_bresp         (o_bresp),
      .i_bready        (bready),
      .i_arvalid       (arvalid),
      .i_araddr        (araddr),
      .i_arready       (o_arready),
      .i_rvalid        (o_rvalid),
      .i_rdata         (o_rdata),
      .i_rresp         (o_rresp),
      .i_rready        (rready),
      .i_status_vdip   (status_vdip),
      .i_status_vled   (o_status_vled),
      .o_error_count   (error_count),
      .o_writes_done   (writes_done),
      .o_reads_done    (reads_done)
   );

   // 100 ns clock
   initial
   begin
      clk_main_a0 = 1'b0;
      forever
         #50 clk_main_a0 = ~clk_main_a0;
   end

   // ----------------------------------------------------------------------
   // Master helpers
   // ----------------------------------------------------------------------

   // Waits edge by edge until the channel shows its handshake
   task automatic wait_for_beat(input int chan, input string name);
      int   cycles;
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen && cycles < TIMEOUT_CYCLES)
      begin
         @(posedge clk_main_a0);
         cycles++;
         case (chan)
            CH_AW:   seen = o_awready;
            CH_W:    seen = o_wready;
            CH_B:    seen = o_bvalid;
            CH_AR:   seen = o_arready;
            default: seen = o_rvalid;
         endcase
      end
      if (!seen)
      begin
         timeout_count++;
         $display("Timeout: no %s handshake within %0d cycles", name, TIMEOUT_CYCLES);
      end
   endtask

   // Mostly the two registers, sometimes anywhere in the low page
   function automatic logic [`OCL_ADDR_W-1:0] pick_address();
      int pick;
      pick = $urandom_range(0, 9);
      if (pick < 4)
         return `HELLO_WORLD_REG_ADDR;
      else if (pick < 8)
         return `VLED_REG_ADDR;
      else
         return $urandom & 32'h0000_0ffc;
   endfunction

   task automatic axi_write(input logic [`OCL_ADDR_W-1:0] addr,
                            input logic [`OCL_DATA_W-1:0] data);
      @(posedge clk_main_a0);
      // Data offered with the address, taken one cycle later at best
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      wait_for_beat(CH_AW, "write address");
      awvalid <= 1'b0;
      wait_for_beat(CH_W, "write data");
      wvalid  <= 1'b0;
      repeat ($urandom_range(0, 4)) @(posedge clk_main_a0);
      bready  <= 1'b1;
      wait_for_beat(CH_B, "write response");
      bready  <= 1'b0;
      writes_issued++;
   endtask

   task automatic axi_read(input logic [`OCL_ADDR_W-1:0] addr);
      @(posedge clk_main_a0);
      arvalid <= 1'b1;
      araddr  <= addr;
      wait_for_beat(CH_AR, "read address");
      arvalid <= 1'b0;
      // Late rready holds rdata for a while
      repeat ($urandom_range(0, 5)) @(posedge clk_main_a0);
      rready  <= 1'b1;
      wait_for_beat(CH_R, "read data");
      rready  <= 1'b0;
      reads_issued++;
   endtask

   task automatic set_dip_switches();
      @(posedge clk_main_a0);
      status_vdip <= $urandom_range(0, 16'hffff);
   endtask

   // ----------------------------------------------------------------------
   // Main sequence
   // ----------------------------------------------------------------------
   initial
   begin
      seed = 32'h5b20;
      void'($urandom(seed));
      timeout_count   = 0;
      count_errors    = 0;
      writes_issued   = 0;
      reads_issued    = 0;
      rst_main_n_sync = 1'b0;
      awvalid         = 1'b0;
      awaddr          = '0;
      wvalid          = 1'b0;
      wdata           = '0;
      bready          = 1'b0;
      arvalid         = 1'b0;
      araddr          = '0;
      rready          = 1'b0;
      status_vdip     = '0;

      repeat (8) @(posedge clk_main_a0);
      rst_main_n_sync <= 1'b1;

      // 45 write, 45 read, 10 switch change
      for (int n = 0; n < NUM_ACCESSES; n++)
      begin
         sel = $urandom_range(0, 99);
         if (sel < 45)
            axi_write(pick_address(), $urandom);
         else if (sel < 90)
            axi_read(pick_address());
         else
            set_dip_switches();
      end

      // Let the LED pipeline drain under the checker
      repeat (10) @(posedge clk_main_a0);

      if (writes_done != writes_issued)
      begin
         count_errors++;
         $display("Write responses seen %0d, but %0d writes were issued",
                  writes_done, writes_issued);
      end
      if (reads_done != reads_issued)
      begin
         count_errors++;
         $display("Read responses seen %0d, but %0d reads were issued",
                  reads_done, reads_issued);
      end

      $display("Error counts: %0d check, %0d timeout, %0d transfer count",
               error_count, timeout_count, count_errors);
      if (error_count + timeout_count + count_errors == 0)
         $display("Simulation finished: PASS");
      else
         $display("Simulation finished: FAIL");
      $finish;
   end

endmodule

`default_nettype wire

// File: list.f
+incdir+.
ocl_hello_pkg.sv
ocl_axil_ctrl.sv
hello_world_reg.sv
vled_status.sv
ocl_rdata_mux.sv
cl_hello_world.sv
tb_ocl_checker.sv
tb_cl_hello_world.sv

// File: Bender.yml
package:
  name: cl_hello_world

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - ocl_hello_pkg.sv
      - ocl_axil_ctrl.sv
      - hello_world_reg.sv
      - vled_status.sv
      - ocl_rdata_mux.sv
      - cl_hello_world.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_ocl_checker.sv
      - tb_cl_hello_world.sv
